//--- rtl/vec_settings.svh
// Size settings for the vector coprocessor.
// Included by the package and by any RTL file that sizes storage directly.
// Change the values here only; the package types follow them.

`ifndef VEC_SETTINGS_SVH
`define VEC_SETTINGS_SVH

// Elements per vector register
`define VEC_NR_ELEMS 4
// Element width in bits
`define VEC_ELEM_W   32
// Number of vector registers
`define VEC_NR_VREGS 8
// Memory word address width
`define VEC_MEM_AW   8
// Instruction tag width
`define VEC_ID_W     4

`endif

//--- rtl/vec_pkg.sv
// Shared types of the vector coprocessor.
// Holds the operation encoding, the dispatched request and the index and
// address types. Modules import it inside their body and use scoped names
// in their port lists.

`include "vec_settings.svh"

package vec_pkg;

  ////////////////////
  // Basic types
  ////////////////////

  // Register index and one-hot register mask
  typedef logic [$clog2(`VEC_NR_VREGS)-1:0] vreg_addr_t;
  typedef logic [`VEC_NR_VREGS-1:0]         vreg_mask_t;

  // Element position inside a register
  typedef logic [$clog2(`VEC_NR_ELEMS)-1:0] elem_idx_t;

  typedef logic [`VEC_ELEM_W-1:0] elem_t;
  typedef logic [`VEC_MEM_AW-1:0] mem_addr_t;
  typedef logic [`VEC_ID_W-1:0]   vec_id_t;

  // Index of the final element of a vector
  localparam elem_idx_t LAST_ELEM = elem_idx_t'(`VEC_NR_ELEMS - 1);

  ////////////////////
  // Instructions
  ////////////////////

  typedef enum logic [2:0] {
    VADD,
    VSUB,
    VAND,
    VXOR,
    VLD,
    VST
  } vec_op_e;

  // Instruction as handed to a unit; vd is the data register for VLD/VST
  typedef struct packed {
    vec_op_e    op;
    vreg_addr_t vd;
    vreg_addr_t vs1;
    vreg_addr_t vs2;
    mem_addr_t  addr;
    vec_id_t    id;
  } vec_req_t;

endpackage

//--- rtl/vec_ifs.sv
// Interfaces between the controller, the two units and the register file.
// unit_if carries a dispatch to a unit and its completion back.
// vrf_port_if is one unit's read/write port into the register file.

// Controller to unit handshake
interface unit_if;
  import vec_pkg::*;

  logic     req_valid;
  vec_req_t req;
  logic     busy;
  logic     done;
  vec_id_t  done_id;

  modport ctrl (
    output req_valid, req,
    input  busy, done, done_id
  );

  modport unit (
    input  req_valid, req,
    output busy, done, done_id
  );
endinterface

// Register file port owned by one unit
interface vrf_port_if;
  import vec_pkg::*;

  // Reads, combinational; second channel shares the element index
  vreg_addr_t raddr;
  vreg_addr_t raddr2;
  elem_idx_t  ridx;
  elem_t      rdata;
  elem_t      rdata2;
  // Write, taken at the clock edge
  logic       we;
  vreg_addr_t waddr;
  elem_idx_t  widx;
  elem_t      wdata;

  modport unit (
    output raddr, raddr2, ridx, we, waddr, widx, wdata,
    input  rdata, rdata2
  );

  modport vrf (
    input  raddr, raddr2, ridx, we, waddr, widx, wdata,
    output rdata, rdata2
  );
endinterface

//--- rtl/vec_vrf.sv
// Vector register file.
// Serves one port for the VFU and one for the VLSU. Reads are combinational
// on both channels of a port, writes land at the clock edge. The scoreboard
// keeps the two writers on different registers.

`include "vec_settings.svh"

module vec_vrf (
  input  logic   clk_i,
  input  logic   rst_n_i,
  vrf_port_if.vrf vfu_port,
  vrf_port_if.vrf lsu_port
);
  import vec_pkg::*;

  // Storage, one element per entry
  elem_t regs_q [`VEC_NR_VREGS][`VEC_NR_ELEMS];

  ////////////////////
  // Write ports
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int r = 0; r < `VEC_NR_VREGS; r++) begin
        for (int e = 0; e < `VEC_NR_ELEMS; e++) begin
          regs_q[r][e] <= '0;
        end
      end
    end else begin
      if (vfu_port.we) begin
        regs_q[vfu_port.waddr][vfu_port.widx] <= vfu_port.wdata;
      end
      if (lsu_port.we) begin
        regs_q[lsu_port.waddr][lsu_port.widx] <= lsu_port.wdata;
      end
    end
  end

  ////////////////////
  // Read ports
  ////////////////////

  // VFU operand pair
  assign vfu_port.rdata  = regs_q[vfu_port.raddr][vfu_port.ridx];
  assign vfu_port.rdata2 = regs_q[vfu_port.raddr2][vfu_port.ridx];

  // Store data; the second channel sits on register zero
  assign lsu_port.rdata  = regs_q[lsu_port.raddr][lsu_port.ridx];
  assign lsu_port.rdata2 = regs_q[lsu_port.raddr2][lsu_port.ridx];

endmodule

//--- rtl/vec_vfu.sv
// Element-wise arithmetic unit.
// Takes one instruction at a time from the controller, reads vs1 and vs2 and
// writes vd one element per cycle, then pulses done with the instruction id.
// Busy covers the whole span from the cycle after acceptance to done.

module vec_vfu (
  input  logic     clk_i,
  input  logic     rst_n_i,
  unit_if.unit     ctrl,
  vrf_port_if.unit vrf
);
  import vec_pkg::*;

  vec_req_t  req_q;
  logic      run_q;
  logic      busy_q;
  logic      done_q;
  elem_idx_t cnt_q;
  elem_t     result;

  ////////////////////
  // Sequencing
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      run_q  <= 1'b0;
      busy_q <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else begin
      done_q <= 1'b0;
      if (ctrl.req_valid) begin
        run_q  <= 1'b1;
        busy_q <= 1'b1;
        cnt_q  <= '0;
      end else if (run_q) begin
        cnt_q <= cnt_q + 1'b1;
        if (cnt_q == LAST_ELEM) begin
          run_q  <= 1'b0;
          done_q <= 1'b1;
        end
      end
      // Controller queue always takes the done pulse
      if (done_q) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Instruction payload
  always_ff @(posedge clk_i) begin
    if (ctrl.req_valid) begin
      req_q <= ctrl.req;
    end
  end

  ////////////////////
  // Datapath
  ////////////////////

  always_comb begin
    case (req_q.op)
      VADD:    result = vrf.rdata + vrf.rdata2;
      VSUB:    result = vrf.rdata - vrf.rdata2;
      VAND:    result = vrf.rdata & vrf.rdata2;
      VXOR:    result = vrf.rdata ^ vrf.rdata2;
      default: result = '0;
    endcase
  end

  // Both operands and the result sit at the same element
  assign vrf.raddr  = req_q.vs1;
  assign vrf.raddr2 = req_q.vs2;
  assign vrf.ridx   = cnt_q;
  assign vrf.we     = run_q;
  assign vrf.waddr  = req_q.vd;
  assign vrf.widx   = cnt_q;
  assign vrf.wdata  = result;

  assign ctrl.busy    = busy_q;
  assign ctrl.done    = done_q;
  assign ctrl.done_id = req_q.id;

endmodule

//--- rtl/vec_vlsu.sv
// Load/store unit.
// Moves one vector register between memory and the register file, one word
// request per element at consecutive addresses from the base. Loads may have
// several requests outstanding; responses return in order and are written
// as they arrive. Done pulses after the last response (load) or the last
// accepted request (store).

module vec_vlsu (
  input  logic               clk_i,
  input  logic               rst_n_i,
  unit_if.unit               ctrl,
  vrf_port_if.unit           vrf,
  // Memory port
  output logic               mem_req_valid_o,
  input  logic               mem_req_ready_i,
  output logic               mem_req_write_o,
  output vec_pkg::mem_addr_t mem_req_addr_o,
  output vec_pkg::elem_t     mem_req_wdata_o,
  input  logic               mem_resp_valid_i,
  input  vec_pkg::elem_t     mem_resp_data_i
);
  import vec_pkg::*;

  vec_req_t  req_q;
  logic      active_q;
  logic      req_done_q;
  logic      busy_q;
  logic      done_q;
  elem_idx_t req_cnt_q;
  elem_idx_t rsp_cnt_q;
  logic      is_store;
  logic      req_fire;
  logic      rsp_fire;

  assign is_store = (req_q.op == VST);
  assign req_fire = mem_req_valid_o & mem_req_ready_i;
  // Responses only ever belong to a load in flight
  assign rsp_fire = mem_resp_valid_i & active_q & ~is_store;

  ////////////////////
  // Control
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      active_q   <= 1'b0;
      req_done_q <= 1'b0;
      busy_q     <= 1'b0;
      done_q     <= 1'b0;
      req_cnt_q  <= '0;
      rsp_cnt_q  <= '0;
    end else begin
      done_q <= 1'b0;
      if (ctrl.req_valid) begin
        active_q   <= 1'b1;
        req_done_q <= 1'b0;
        busy_q     <= 1'b1;
        req_cnt_q  <= '0;
        rsp_cnt_q  <= '0;
      end else begin
        if (req_fire) begin
          req_cnt_q <= req_cnt_q + 1'b1;
          if (req_cnt_q == LAST_ELEM) begin
            req_done_q <= 1'b1;
            // Stores finish with their last request
            if (is_store) begin
              active_q <= 1'b0;
              done_q   <= 1'b1;
            end
          end
        end
        if (rsp_fire) begin
          rsp_cnt_q <= rsp_cnt_q + 1'b1;
          if (rsp_cnt_q == LAST_ELEM) begin
            active_q <= 1'b0;
            done_q   <= 1'b1;
          end
        end
      end
      if (done_q) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (ctrl.req_valid) begin
      req_q <= ctrl.req;
    end
  end

  ////////////////////
  // Memory and VRF
  ////////////////////

  assign mem_req_valid_o = active_q & ~req_done_q;
  assign mem_req_write_o = is_store;
  assign mem_req_addr_o  = req_q.addr + mem_addr_t'(req_cnt_q);
  assign mem_req_wdata_o = vrf.rdata;

  // Store data follows the request counter
  assign vrf.raddr  = req_q.vd;
  assign vrf.raddr2 = '0;
  assign vrf.ridx   = req_cnt_q;

  // Load data follows the response counter
  assign vrf.we    = rsp_fire;
  assign vrf.waddr = req_q.vd;
  assign vrf.widx  = rsp_cnt_q;
  assign vrf.wdata = mem_resp_data_i;

  assign ctrl.busy    = busy_q;
  assign ctrl.done    = done_q;
  assign ctrl.done_id = req_q.id;

endmodule

//--- rtl/vec_controller.sv
// Issue and completion control.
// Accepts instructions from the core, checks register hazards against the
// other unit, and dispatches to the VFU or the VLSU one cycle later. Each unit
// owns at most one instruction until its result is accepted by the core.
// Done pulses are merged into a two-entry queue that drives the result port.

module vec_controller (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // Issue port
  input  logic                x_issue_valid_i,
  output logic                x_issue_ready_o,
  input  vec_pkg::vec_op_e    x_issue_op_i,
  input  vec_pkg::vreg_addr_t x_issue_vd_i,
  input  vec_pkg::vreg_addr_t x_issue_vs1_i,
  input  vec_pkg::vreg_addr_t x_issue_vs2_i,
  input  vec_pkg::mem_addr_t  x_issue_addr_i,
  input  vec_pkg::vec_id_t    x_issue_id_i,
  // Result port
  output logic                x_result_valid_o,
  input  logic                x_result_ready_i,
  output vec_pkg::vec_id_t    x_result_id_o,
  // Units
  unit_if.ctrl                vfu,
  unit_if.ctrl                vlsu
);
  import vec_pkg::*;

  function automatic vreg_mask_t reg_bit(input vreg_addr_t a);
    return vreg_mask_t'(1) << a;
  endfunction

  vec_req_t         issue_req;
  logic             issue_lsu;
  logic             other;
  logic             issue_fire;
  logic             unit_busy;
  logic             hazard;
  vreg_mask_t       new_wr;
  vreg_mask_t       new_rd;
  logic             ready_en_q;
  logic             disp_valid_q;
  logic             disp_lsu_q;
  vec_req_t         disp_req_q;
  // Per unit, index 1 is the VLSU
  logic       [1:0] owed_q;
  vreg_mask_t [1:0] sb_wr_q;
  vreg_mask_t [1:0] sb_rd_q;
  // Completion queue
  vec_id_t    [1:0] q_id_q;
  vec_id_t    [1:0] q_id_d;
  logic       [1:0] q_unit_q;
  logic       [1:0] q_unit_d;
  logic       [1:0] q_cnt_q;
  logic       [1:0] q_cnt_d;
  logic             pop;

  ////////////////////
  // Issue check
  ////////////////////

  assign issue_req = '{op: x_issue_op_i, vd: x_issue_vd_i, vs1: x_issue_vs1_i,
                       vs2: x_issue_vs2_i, addr: x_issue_addr_i, id: x_issue_id_i};
  assign issue_lsu = (x_issue_op_i == VLD) || (x_issue_op_i == VST);
  assign other     = ~issue_lsu;
  assign unit_busy = issue_lsu ? vlsu.busy : vfu.busy;

  // Register footprint of the incoming instruction
  always_comb begin
    new_wr = '0;
    new_rd = '0;
    case (x_issue_op_i)
      VLD:     new_wr = reg_bit(x_issue_vd_i);
      VST:     new_rd = reg_bit(x_issue_vd_i);
      default: begin
        new_wr = reg_bit(x_issue_vd_i);
        new_rd = reg_bit(x_issue_vs1_i) | reg_bit(x_issue_vs2_i);
      end
    endcase
  end

  assign hazard = owed_q[other] &&
                  ((((new_wr | new_rd) & sb_wr_q[other]) != '0) ||
                   ((new_wr & (sb_wr_q[other] | sb_rd_q[other])) != '0));

  assign x_issue_ready_o = ready_en_q & ~disp_valid_q & ~unit_busy &
                           ~owed_q[issue_lsu] & ~hazard;
  assign issue_fire      = x_issue_valid_i & x_issue_ready_o;

  ////////////////////
  // Dispatch and scoreboard
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ready_en_q   <= 1'b0;
      disp_valid_q <= 1'b0;
      disp_lsu_q   <= 1'b0;
      owed_q       <= '0;
    end else begin
      ready_en_q   <= 1'b1;
      disp_valid_q <= issue_fire;
      if (pop) begin
        owed_q[q_unit_q[0]] <= 1'b0;
      end
      if (issue_fire) begin
        disp_lsu_q         <= issue_lsu;
        owed_q[issue_lsu]  <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_fire) begin
      disp_req_q         <= issue_req;
      sb_wr_q[issue_lsu] <= new_wr;
      sb_rd_q[issue_lsu] <= new_rd;
    end
  end

  assign vfu.req_valid  = disp_valid_q & ~disp_lsu_q;
  assign vfu.req        = disp_req_q;
  assign vlsu.req_valid = disp_valid_q & disp_lsu_q;
  assign vlsu.req       = disp_req_q;

  ////////////////////
  // Completion queue
  ////////////////////

  assign pop = x_result_valid_o & x_result_ready_i;

  // Pop first, then append; the VFU goes in ahead of the VLSU
  always_comb begin : q_next
    logic [1:0] cnt;
    q_id_d   = q_id_q;
    q_unit_d = q_unit_q;
    cnt      = q_cnt_q;
    if (pop) begin
      q_id_d[0]   = q_id_q[1];
      q_unit_d[0] = q_unit_q[1];
      cnt         = cnt - 1'b1;
    end
    if (vfu.done) begin
      q_id_d[cnt[0]]   = vfu.done_id;
      q_unit_d[cnt[0]] = 1'b0;
      cnt              = cnt + 1'b1;
    end
    if (vlsu.done) begin
      q_id_d[cnt[0]]   = vlsu.done_id;
      q_unit_d[cnt[0]] = 1'b1;
      cnt              = cnt + 1'b1;
    end
    q_cnt_d = cnt;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      q_cnt_q  <= '0;
      q_unit_q <= '0;
    end else begin
      q_cnt_q  <= q_cnt_d;
      q_unit_q <= q_unit_d;
    end
  end

  always_ff @(posedge clk_i) begin
    q_id_q <= q_id_d;
  end

  assign x_result_valid_o = (q_cnt_q != '0);
  assign x_result_id_o    = q_id_q[0];

endmodule

//--- rtl/vec_top.sv
// Top level of the vector coprocessor.
// Connects the controller, the arithmetic unit, the load/store unit and the
// register file. The core sees an issue port, a result port and one memory
// port, all as plain signals.

module vec_top (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // Issue port
  input  logic                x_issue_valid_i,
  output logic                x_issue_ready_o,
  input  vec_pkg::vec_op_e    x_issue_op_i,
  input  vec_pkg::vreg_addr_t x_issue_vd_i,
  input  vec_pkg::vreg_addr_t x_issue_vs1_i,
  input  vec_pkg::vreg_addr_t x_issue_vs2_i,
  input  vec_pkg::mem_addr_t  x_issue_addr_i,
  input  vec_pkg::vec_id_t    x_issue_id_i,
  // Result port
  output logic                x_result_valid_o,
  input  logic                x_result_ready_i,
  output vec_pkg::vec_id_t    x_result_id_o,
  // Memory port
  output logic                mem_req_valid_o,
  input  logic                mem_req_ready_i,
  output logic                mem_req_write_o,
  output vec_pkg::mem_addr_t  mem_req_addr_o,
  output vec_pkg::elem_t      mem_req_wdata_o,
  input  logic                mem_resp_valid_i,
  input  vec_pkg::elem_t      mem_resp_data_i
);

  // Dispatch and completion links
  unit_if vfu_unit ();
  unit_if vlsu_unit ();

  // Register file ports
  vrf_port_if vfu_vrf ();
  vrf_port_if vlsu_vrf ();

  vec_controller u_controller (
    .clk_i           (clk_i           ),
    .rst_n_i         (rst_n_i         ),
    .x_issue_valid_i (x_issue_valid_i ),
    .x_issue_ready_o (x_issue_ready_o ),
    .x_issue_op_i    (x_issue_op_i    ),
    .x_issue_vd_i    (x_issue_vd_i    ),
    .x_issue_vs1_i   (x_issue_vs1_i   ),
    .x_issue_vs2_i   (x_issue_vs2_i   ),
    .x_issue_addr_i  (x_issue_addr_i  ),
    .x_issue_id_i    (x_issue_id_i    ),
    .x_result_valid_o(x_result_valid_o),
    .x_result_ready_i(x_result_ready_i),
    .x_result_id_o   (x_result_id_o   ),
    .vfu             (vfu_unit        ),
    .vlsu            (vlsu_unit       )
  );

  vec_vfu u_vfu (
    .clk_i  (clk_i   ),
    .rst_n_i(rst_n_i ),
    .ctrl   (vfu_unit),
    .vrf    (vfu_vrf )
  );

  vec_vlsu u_vlsu (
    .clk_i           (clk_i           ),
    .rst_n_i         (rst_n_i         ),
    .ctrl            (vlsu_unit       ),
    .vrf             (vlsu_vrf        ),
    .mem_req_valid_o (mem_req_valid_o ),
    .mem_req_ready_i (mem_req_ready_i ),
    .mem_req_write_o (mem_req_write_o ),
    .mem_req_addr_o  (mem_req_addr_o  ),
    .mem_req_wdata_o (mem_req_wdata_o ),
    .mem_resp_valid_i(mem_resp_valid_i),
    .mem_resp_data_i (mem_resp_data_i )
  );

  vec_vrf u_vrf (
    .clk_i   (clk_i   ),
    .rst_n_i (rst_n_i ),
    .vfu_port(vfu_vrf ),
    .lsu_port(vlsu_vrf)
  );

endmodule

//--- verif/tb_clkgen.sv
// Clock and reset source for the testbench.
// Clock period is 100; reset is held low over the first three rising edges.

module tb_clkgen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  // Release lands at the usual drive offset after the third edge
  initial begin
    rst_n_o = 1'b0;
    repeat (3) @(posedge clk_o);
    #10;
    rst_n_o = 1'b1;
  end

endmodule

//--- verif/vec_tb.sv
// Testbench for the vector coprocessor.
// Runs a fixed instruction program through the issue port, serves the memory
// port from a word memory with random back-pressure and read latency, and
// checks memory writes and result ids against a shadow model updated at issue.

`include "vec_settings.svh"

module vec_tb;
  import vec_pkg::*;

  localparam int NR_INSTR       = 19;
  localparam int TIMEOUT_CYCLES = NR_INSTR * 40 + 100;
  localparam int MEM_WORDS      = 1 << `VEC_MEM_AW;

  logic       clk;
  logic       rst_n;
  logic       issue_valid;
  logic       issue_ready;
  vec_op_e    issue_op;
  vreg_addr_t issue_vd;
  vreg_addr_t issue_vs1;
  vreg_addr_t issue_vs2;
  mem_addr_t  issue_addr;
  vec_id_t    issue_id;
  logic       result_valid;
  logic       result_ready;
  vec_id_t    result_id;
  logic       mem_req_valid;
  logic       mem_req_ready;
  logic       mem_req_write;
  mem_addr_t  mem_req_addr;
  elem_t      mem_req_wdata;
  logic       mem_resp_valid;
  elem_t      mem_resp_data;
  logic       wr_fire;

  // Memory model and shadow state
  elem_t      mem [MEM_WORDS];
  elem_t      shadow_mem [MEM_WORDS];
  elem_t      shadow_vrf [`VEC_NR_VREGS][`VEC_NR_ELEMS];
  mem_addr_t  exp_wr_addr_q [$];
  elem_t      exp_wr_data_q [$];
  mem_addr_t  rd_addr_q [$];
  int         rd_due_q [$];
  // Instructions still waiting for their result, oldest first
  vec_id_t    out_id [$];
  vreg_mask_t out_wr [$];
  vreg_mask_t out_rd [$];
  vec_id_t    got_ids [$];

  integer     seed         = 32'h9647ff3f;
  int         errors       = 0;
  int         cyc          = 0;
  int         nr_issued    = 0;
  int         rd_resp_cnt  = 0;
  logic       stall_mem    = 1'b0;
  logic       stall_now    = 1'b0;
  logic       expect_stall = 1'b0;
  logic       wr_pending   = 1'b0;
  mem_addr_t  exp_wr_addr  = '0;
  elem_t      exp_wr_data  = '0;
  logic       result_hold  = 1'b0;
  vec_id_t    held_id      = '0;
  logic       mem_hold     = 1'b0;
  mem_addr_t  held_addr    = '0;

  tb_clkgen u_clkgen (
    .clk_o  (clk  ),
    .rst_n_o(rst_n)
  );

  vec_top u_vec_top (
    .clk_i           (clk           ),
    .rst_n_i         (rst_n         ),
    .x_issue_valid_i (issue_valid   ),
    .x_issue_ready_o (issue_ready   ),
    .x_issue_op_i    (issue_op      ),
    .x_issue_vd_i    (issue_vd      ),
    .x_issue_vs1_i   (issue_vs1     ),
    .x_issue_vs2_i   (issue_vs2     ),
    .x_issue_addr_i  (issue_addr    ),
    .x_issue_id_i    (issue_id      ),
    .x_result_valid_o(result_valid  ),
    .x_result_ready_i(result_ready  ),
    .x_result_id_o   (result_id     ),
    .mem_req_valid_o (mem_req_valid ),
    .mem_req_ready_i (mem_req_ready ),
    .mem_req_write_o (mem_req_write ),
    .mem_req_addr_o  (mem_req_addr  ),
    .mem_req_wdata_o (mem_req_wdata ),
    .mem_resp_valid_i(mem_resp_valid),
    .mem_resp_data_i (mem_resp_data )
  );

  assign wr_fire = mem_req_valid & mem_req_ready & mem_req_write;

  ////////////////////
  // Reference rules
  ////////////////////

  // Preset contents that depend on every address bit
  function automatic elem_t fill_word(input mem_addr_t a);
    return {a, ~a, a ^ 8'h3c, a + 8'h5a};
  endfunction

  function automatic elem_t apply_op(input vec_op_e op, input elem_t a, input elem_t b);
    case (op)
      VADD:    return a + b;
      VSUB:    return a - b;
      VAND:    return a & b;
      default: return a ^ b;
    endcase
  endfunction

  // Shadow update at the issue transfer, plus the register footprint
  task automatic record_issue(input vec_op_e op, input vreg_addr_t vd, input vreg_addr_t vs1,
                              input vreg_addr_t vs2, input mem_addr_t addr,
                              input vec_id_t id);
    vreg_mask_t wr;
    vreg_mask_t rd;
    mem_addr_t  a;
    wr = '0;
    rd = '0;
    for (int e = 0; e < `VEC_NR_ELEMS; e++) begin
      a = addr + mem_addr_t'(e);
      case (op)
        VLD: shadow_vrf[vd][e] = shadow_mem[a];
        VST: begin
          shadow_mem[a] = shadow_vrf[vd][e];
          exp_wr_addr_q.push_back(a);
          exp_wr_data_q.push_back(shadow_vrf[vd][e]);
        end
        default: shadow_vrf[vd][e] = apply_op(op, shadow_vrf[vs1][e], shadow_vrf[vs2][e]);
      endcase
    end
    case (op)
      VLD: wr[vd] = 1'b1;
      VST: rd[vd] = 1'b1;
      default: begin
        wr[vd]  = 1'b1;
        rd[vs1] = 1'b1;
        rd[vs2] = 1'b1;
      end
    endcase
    out_id.push_back(id);
    out_wr.push_back(wr);
    out_rd.push_back(rd);
    nr_issued++;
  endtask

  // A result must be outstanding and must not pass an older dependent one
  task automatic record_result(input vec_id_t id);
    int   idx;
    logic conflict;
    idx      = -1;
    conflict = 1'b0;
    for (int i = 0; i < out_id.size(); i++) begin
      if (idx < 0 && out_id[i] == id) begin
        idx = i;
      end
    end
    assert (idx >= 0) else begin
      $display("Result id %h came back but no instruction with that id was waiting", id);
      errors++;
    end
    if (idx >= 0) begin
      for (int j = 0; j < idx; j++) begin
        if (((out_wr[j] & (out_wr[idx] | out_rd[idx])) != '0) ||
            ((out_wr[idx] & out_rd[j]) != '0)) begin
          conflict = 1'b1;
        end
      end
      assert (!conflict) else begin
        $display("Result id %h came back ahead of an older dependent instruction", id);
        errors++;
      end
      out_id.delete(idx);
      out_wr.delete(idx);
      out_rd.delete(idx);
    end
    got_ids.push_back(id);
  endtask

  ////////////////////
  // Memory model
  ////////////////////

  always begin : bus_model
    mem_addr_t ra;
    @(posedge clk);
    cyc++;
    stall_now   = stall_mem;
    result_hold = rst_n && result_valid && !result_ready;
    held_id     = result_id;
    mem_hold    = rst_n && mem_req_valid && !mem_req_ready;
    held_addr   = mem_req_addr;
    if (rst_n && result_valid && result_ready) begin
      record_result(result_id);
    end
    if (rst_n && mem_req_valid && mem_req_ready) begin
      if (mem_req_write) begin
        mem[mem_req_addr] = mem_req_wdata;
        if (exp_wr_addr_q.size() != 0) begin
          void'(exp_wr_addr_q.pop_front());
          void'(exp_wr_data_q.pop_front());
        end
      end else begin
        rd_addr_q.push_back(mem_req_addr);
        rd_due_q.push_back(cyc + 1 + int'($unsigned($random(seed)) % 3));
      end
    end
    #10;
    mem_req_ready = !stall_now && (($random(seed) & 3) != 0);
    // Responses leave in request order and at most one per cycle
    if (rd_addr_q.size() != 0 && rd_due_q[0] <= cyc) begin
      ra = rd_addr_q.pop_front();
      void'(rd_due_q.pop_front());
      mem_resp_valid = 1'b1;
      mem_resp_data  = mem[ra];
      rd_resp_cnt++;
    end else begin
      mem_resp_valid = 1'b0;
      mem_resp_data  = '0;
    end
    wr_pending = (exp_wr_addr_q.size() != 0);
    if (wr_pending) begin
      exp_wr_addr = exp_wr_addr_q[0];
      exp_wr_data = exp_wr_data_q[0];
    end
  end

  ////////////////////
  // Assertions
  ////////////////////

  assert property (@(posedge clk) (cyc > 0 && !rst_n) |-> !issue_ready)
    else begin
      $display("CHECK FAILED x_issue_ready_o: expected 0 got %h", $sampled(issue_ready));
      errors++;
    end
  assert property (@(posedge clk) (cyc > 0 && !rst_n) |-> !result_valid)
    else begin
      $display("CHECK FAILED x_result_valid_o: expected 0 got %h", $sampled(result_valid));
      errors++;
    end
  assert property (@(posedge clk) (cyc > 0 && !rst_n) |-> !mem_req_valid)
    else begin
      $display("CHECK FAILED mem_req_valid_o: expected 0 got %h", $sampled(mem_req_valid));
      errors++;
    end

  // Result and memory request hold while not accepted
  assert property (@(posedge clk) disable iff (!rst_n) result_hold |-> result_valid)
    else begin
      $display("CHECK FAILED x_result_valid_o: expected 1 got %h", $sampled(result_valid));
      errors++;
    end
  assert property (@(posedge clk) disable iff (!rst_n) result_hold |-> result_id == held_id)
    else begin
      $display("CHECK FAILED x_result_id_o: expected %h got %h",
               $sampled(held_id), $sampled(result_id));
      errors++;
    end
  assert property (@(posedge clk) disable iff (!rst_n) mem_hold |-> mem_req_valid)
    else begin
      $display("CHECK FAILED mem_req_valid_o: expected 1 got %h", $sampled(mem_req_valid));
      errors++;
    end
  assert property (@(posedge clk) disable iff (!rst_n)
                   mem_hold |-> mem_req_addr == held_addr)
    else begin
      $display("CHECK FAILED mem_req_addr_o: expected %h got %h",
               $sampled(held_addr), $sampled(mem_req_addr));
      errors++;
    end

  // Store traffic against the shadow memory
  assert property (@(posedge clk) disable iff (!rst_n) wr_fire |-> wr_pending)
    else begin
      $display("Memory write to %h arrived with no store waiting", $sampled(mem_req_addr));
      errors++;
    end
  assert property (@(posedge clk) disable iff (!rst_n)
                   (wr_fire && wr_pending) |-> mem_req_addr == exp_wr_addr)
    else begin
      $display("CHECK FAILED mem_req_addr_o: expected %h got %h",
               $sampled(exp_wr_addr), $sampled(mem_req_addr));
      errors++;
    end
  assert property (@(posedge clk) disable iff (!rst_n)
                   (wr_fire && wr_pending) |-> mem_req_wdata == exp_wr_data)
    else begin
      $display("CHECK FAILED mem_req_wdata_o: expected %h got %h",
               $sampled(exp_wr_data), $sampled(mem_req_wdata));
      errors++;
    end

  assert property (@(posedge clk) disable iff (!rst_n) expect_stall |-> !issue_ready)
    else begin
      $display("CHECK FAILED x_issue_ready_o: expected 0 got %h", $sampled(issue_ready));
      errors++;
    end

  ////////////////////
  // Stimulus
  ////////////////////

  task automatic drive_issue(input vec_op_e op, input vreg_addr_t vd, input vreg_addr_t vs1,
                             input vreg_addr_t vs2, input mem_addr_t addr);
    issue_valid = 1'b1;
    issue_op    = op;
    issue_vd    = vd;
    issue_vs1   = vs1;
    issue_vs2   = vs2;
    issue_addr  = addr;
    issue_id    = vec_id_t'(nr_issued);
  endtask

  // Returns at the drive offset after the transfer edge
  task automatic issue(input vec_op_e op, input vreg_addr_t vd, input vreg_addr_t vs1,
                       input vreg_addr_t vs2, input mem_addr_t addr);
    drive_issue(op, vd, vs1, vs2, addr);
    @(posedge clk);
    while (!issue_ready) begin
      @(posedge clk);
    end
    record_issue(op, vd, vs1, vs2, addr, issue_id);
    #10;
    issue_valid = 1'b0;
  endtask

  task automatic wait_idle();
    while (out_id.size() != 0) begin
      @(posedge clk);
      #10;
    end
  endtask

  initial begin : program_run
    vec_op_e arith_ops [4];
    vec_id_t vadd_id;
    int      first_idx;
    int      resp_target;
    arith_ops = '{VADD, VSUB, VAND, VXOR};
    issue_valid    = 1'b0;
    issue_op       = VADD;
    issue_vd       = '0;
    issue_vs1      = '0;
    issue_vs2      = '0;
    issue_addr     = '0;
    issue_id       = '0;
    result_ready   = 1'b1;
    mem_req_ready  = 1'b0;
    mem_resp_valid = 1'b0;
    mem_resp_data  = '0;
    for (int a = 0; a < MEM_WORDS; a++) begin
      mem[a]        = fill_word(mem_addr_t'(a));
      shadow_mem[a] = fill_word(mem_addr_t'(a));
    end
    for (int r = 0; r < `VEC_NR_VREGS; r++) begin
      for (int e = 0; e < `VEC_NR_ELEMS; e++) begin
        shadow_vrf[r][e] = '0;
      end
    end
    @(posedge rst_n);

    // Load two sources and copy one back out
    issue(VLD, 3'd1, 3'd0, 3'd0, 8'h10);
    issue(VLD, 3'd2, 3'd0, 3'd0, 8'h20);
    issue(VST, 3'd1, 3'd0, 3'd0, 8'h80);

    // Each operation into its own register, then stored
    for (int i = 0; i < 4; i++) begin
      issue(arith_ops[i], vreg_addr_t'(3 + i), 3'd1, 3'd2, 8'h00);
      issue(VST, vreg_addr_t'(3 + i), 3'd0, 3'd0, mem_addr_t'(8'h84 + 4 * i));
    end
    wait_idle();

    // Independent add overtakes a load held up by the memory
    stall_mem = 1'b1;
    issue(VLD, 3'd7, 3'd0, 3'd0, 8'h30);
    first_idx = got_ids.size();
    vadd_id   = vec_id_t'(nr_issued);
    issue(VADD, 3'd0, 3'd1, 3'd2, 8'h00);
    while (got_ids.size() == first_idx) begin
      @(posedge clk);
      #10;
    end
    assert (got_ids[first_idx] == vadd_id) else begin
      $display("CHECK FAILED x_result_id_o: expected %h got %h", vadd_id, got_ids[first_idx]);
      errors++;
    end
    stall_mem = 1'b0;
    issue(VST, 3'd7, 3'd0, 3'd0, 8'hA0);
    wait_idle();

    // Both units finish with the result port blocked
    result_ready = 1'b0;
    issue(VSUB, 3'd3, 3'd1, 3'd2, 8'h00);
    resp_target = rd_resp_cnt + `VEC_NR_ELEMS;
    issue(VLD, 3'd4, 3'd0, 3'd0, 8'h40);
    drive_issue(VXOR, 3'd5, 3'd3, 3'd4, 8'h00);
    expect_stall = 1'b1;
    @(posedge clk);
    while (!(result_valid && rd_resp_cnt >= resp_target)) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);
    #10;
    expect_stall = 1'b0;
    result_ready = 1'b1;
    issue(VXOR, 3'd5, 3'd3, 3'd4, 8'h00);
    issue(VST, 3'd5, 3'd0, 3'd0, 8'hA4);
    issue(VST, 3'd4, 3'd0, 3'd0, 8'hA8);
    wait_idle();

    // Every store has finished, so all of its writes must have been seen
    assert (exp_wr_addr_q.size() == 0) else begin
      $display("%0d expected memory writes never arrived", exp_wr_addr_q.size());
      errors++;
    end
    assert (got_ids.size() == nr_issued) else begin
      $display("Issued %0d instructions but %0d results came back", nr_issued, got_ids.size());
      errors++;
    end
    $display("Instructions %0d, results %0d, errors %0d", nr_issued, got_ids.size(), errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Timeout: the program did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

//--- all.f
+incdir+rtl
rtl/vec_pkg.sv
rtl/vec_ifs.sv
rtl/vec_vrf.sv
rtl/vec_vfu.sv
rtl/vec_vlsu.sv
rtl/vec_controller.sv
rtl/vec_top.sv
verif/tb_clkgen.sv
verif/vec_tb.sv
